// ==== st_source.f ====
source/st_source_pkg.sv
source/st_transaction_fifo.sv
source/st_beat_driver.sv
source/st_backpressure_monitor.sv
source/st_source_top.sv
sim/clock_gen.sv
sim/st_source_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the streaming packet source testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module st_source_tb -f st_source.f -o st_source_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/st_source_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
   echo "simulation reported failure, see $log"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

exit 0

// ==== sim/st_source_tb.sv ====
// testbench for the streaming packet source; random beats and ready checked against a model
`timescale 1ns/1ps

module st_source_tb
   import st_source_pkg::*;
();

   logic     clk;
   logic     por_reset;
   logic     rerun_reset;
   logic     reset;
   logic     push;
   data_t    push_data;
   channel_t push_channel;
   logic     push_sop;
   logic     push_eop;
   error_t   push_error;
   empty_t   push_empty;
   idle_t    push_idles;
   logic     src_ready;
   logic     full;
   logic     src_valid;
   data_t    src_data;
   channel_t src_channel;
   logic     src_sop;
   logic     src_eop;
   error_t   src_error;
   empty_t   src_empty;
   logic     resp_valid;
   latency_t resp_latency;
   count_t   resp_count;
   logic     complete;
   logic     timeout;

   typedef struct packed {
      data_t    data;
      channel_t channel;
      logic     sop;
      logic     eop;
      error_t   error;
      empty_t   empty;
      idle_t    idles;
   } beat_t;

   // model state, written at the falling edge only
   beat_t    expected[$];
   beat_t    held;
   beat_t    front;
   integer   seed;
   int       cycle_count;
   int       error_count;
   int       gap_cnt;
   int       stall_cnt;
   logic     prev_stall;
   logic     resp_due;
   logic     more_queued;
   latency_t exp_latency;
   count_t   resp_index;
   logic     seen_timeout;

   // second reset for the last test
   assign reset = por_reset || rerun_reset;

   clock_gen u_clock (.clk(clk), .reset(por_reset));

   st_source_top dut (.*);

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------

   task automatic stop_on_error();
      error_count++;
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_channel(input string name, input channel_t exp, input channel_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_error(input string name, input error_t exp, input error_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_empty(input string name, input empty_t exp, input empty_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_latency(input string name, input latency_t exp, input latency_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_count(input string name, input count_t exp, input count_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
         stop_on_error();
      end
   endtask

   // ------------------------------------------------------------------------
   // reference model, sampled mid-cycle where every output has settled
   // ------------------------------------------------------------------------

   always @(negedge clk) begin
      if (reset) begin
         expected.delete();
         gap_cnt     = 0;
         stall_cnt   = 0;
         prev_stall  = 1'b0;
         resp_due    = 1'b0;
         more_queued = 1'b0;
         resp_index  = '0;
      end else begin
         // response one cycle after each acceptance
         check_flag("response strobe", resp_due, resp_valid);
         if (resp_due) begin
            check_latency("response latency", exp_latency, resp_latency);
            check_count("response count", resp_index, resp_count);
            resp_index = resp_index + 1'b1;
         end
         // stalled beat must not move
         if (prev_stall) begin
            check_flag("valid held under stall", 1'b1, src_valid);
            check_data("data held under stall", held.data, src_data);
            check_channel("channel held under stall", held.channel, src_channel);
            check_flag("sop held under stall", held.sop, src_sop);
            check_flag("eop held under stall", held.eop, src_eop);
            check_error("error held under stall", held.error, src_error);
            check_empty("empty held under stall", held.empty, src_empty);
         end
         // queued beat with no idles follows on the very next cycle
         if (more_queued && expected.size() != 0 && expected[0].idles == '0)
            check_flag("back to back beat", 1'b1, src_valid);
         resp_due    = src_valid && src_ready;
         prev_stall  = src_valid && !src_ready;
         more_queued = 1'b0;
         if (src_valid && src_ready) begin
            if (expected.size() == 0) begin
               $display("a beat was accepted while the model expected none");
               stop_on_error();
            end
            front = expected.pop_front();
            check_data("beat data", front.data, src_data);
            check_channel("beat channel", front.channel, src_channel);
            check_flag("beat sop", front.sop, src_sop);
            check_flag("beat eop", front.eop, src_eop);
            check_error("beat error", front.error, src_error);
            check_empty("beat empty", front.empty, src_empty);
            check_flag($sformatf("idle gap %0d for idles %0d", gap_cnt, front.idles),
               1'b1, gap_cnt >= int'(front.idles));
            exp_latency = latency_t'(stall_cnt);
            stall_cnt   = 0;
            gap_cnt     = 0;
            more_queued = (expected.size() != 0);
         end else if (src_valid) begin
            stall_cnt++;
            held = '{src_data, src_channel, src_sop, src_eop, src_error, src_empty, '0};
         end else begin
            gap_cnt++;
         end
         // this push lands at the coming edge, behind the pop above
         if (push && !full)
            expected.push_back('{push_data, push_channel, push_sop, push_eop,
               push_error, push_empty, push_idles});
      end
   end

   // run limit covers about 1400 cycles of tests with margin
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > 4000) begin
         $display("simulation did not finish within 4000 clock cycles");
         stop_on_error();
      end
   end

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   // a quarter of the beats carry a random idle gap
   task automatic random_beat();
      push_data    = $random(seed);
      push_channel = channel_t'($random(seed));
      push_sop     = $random(seed);
      push_eop     = $random(seed);
      push_error   = error_t'($random(seed));
      push_empty   = empty_t'($random(seed));
      push_idles   = (({$random(seed)} % 4) == 0) ? idle_t'($random(seed)) : '0;
   endtask

   task automatic send_beats(input int n, input int ready_pct);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge clk);
         #1;
         src_ready = ({$random(seed)} % 100) < ready_pct;
         push      = 1'b0;
         if (!full) begin
            random_beat();
            push = 1'b1;
            sent++;
         end
      end
      @(posedge clk);
      #1;
      push = 1'b0;
   endtask

   // keep the sink going until the model holds nothing
   task automatic drain(input int ready_pct);
      while (expected.size() != 0) begin
         @(posedge clk);
         #1;
         src_ready = ({$random(seed)} % 100) < ready_pct;
      end
      @(negedge clk);
   endtask

   task automatic check_reset_state(input string name);
      check_flag({name, " src_valid"}, 1'b0, src_valid);
      check_flag({name, " complete"}, 1'b0, complete);
      check_flag({name, " timeout"}, 1'b0, timeout);
      check_flag({name, " resp_valid"}, 1'b0, resp_valid);
      check_flag({name, " full"}, 1'b0, full);
   endtask

   initial begin
      seed         = 32'ha53eb802;
      cycle_count  = 0;
      error_count  = 0;
      rerun_reset  = 1'b0;
      push         = 1'b0;
      push_data    = '0;
      push_channel = '0;
      push_sop     = 1'b0;
      push_eop     = 1'b0;
      push_error   = '0;
      push_empty   = '0;
      push_idles   = '0;
      src_ready    = 1'b0;
      @(negedge por_reset);
      @(negedge clk);
      check_reset_state("after power-on reset");

      // order, content and idle gaps with the sink always ready
      send_beats(200, 100);
      drain(100);
      check_flag("complete after first drain", 1'b1, complete);

      // about 60% ready
      send_beats(200, 60);
      drain(60);
      check_flag("complete after second drain", 1'b1, complete);

      // one beat into a stalled sink clears complete
      @(posedge clk);
      #1;
      random_beat();
      push_idles = '0;
      push       = 1'b1;
      src_ready  = 1'b0;
      @(posedge clk);
      #1;
      push = 1'b0;
      @(negedge clk);
      check_flag("complete after push", 1'b0, complete);

      // that beat keeps waiting until the timeout flag sets and sticks
      seen_timeout = 1'b0;
      repeat (20) begin
         @(negedge clk);
         if (seen_timeout)
            check_flag("timeout stays high", 1'b1, timeout);
         seen_timeout = timeout;
      end
      check_flag("timeout after long stall", 1'b1, timeout);

      @(posedge clk);
      #1;
      rerun_reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rerun_reset = 1'b0;
      @(negedge clk);
      check_reset_state("after second reset");

      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== sim/clock_gen.sv ====
// testbench clock and power-on reset; 10 ns period, reset held high for two rising edges
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic reset
);

   // half period of 5 ns
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release just after the second rising edge
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

// ==== source/st_source_top.sv ====
// streaming packet source top; connects transaction queue, beat driver and back-pressure monitor
`timescale 1ns/1ps

module st_source_top
   import st_source_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   // host push side
   input  logic     push,
   input  data_t    push_data,
   input  channel_t push_channel,
   input  logic     push_sop,
   input  logic     push_eop,
   input  error_t   push_error,
   input  empty_t   push_empty,
   input  idle_t    push_idles,
   output logic     full,
   // stream source side
   input  logic     src_ready,
   output logic     src_valid,
   output data_t    src_data,
   output channel_t src_channel,
   output logic     src_sop,
   output logic     src_eop,
   output error_t   src_error,
   output empty_t   src_empty,
   // responses and status
   output logic     resp_valid,
   output latency_t resp_latency,
   output count_t   resp_count,
   output logic     complete,
   output logic     timeout
);

   // head of queue toward the driver
   data_t    head_data;
   channel_t head_channel;
   logic     head_sop;
   logic     head_eop;
   error_t   head_error;
   empty_t   head_empty;
   idle_t    head_idles;
   logic     fifo_empty;
   logic     pop;

   // ------------------------------------------------------------------------
   // transaction queue
   // ------------------------------------------------------------------------

   st_transaction_fifo u_fifo (
      .clk          (clk),
      .reset        (reset),
      .push         (push),
      .push_data    (push_data),
      .push_channel (push_channel),
      .push_sop     (push_sop),
      .push_eop     (push_eop),
      .push_error   (push_error),
      .push_empty   (push_empty),
      .push_idles   (push_idles),
      .pop          (pop),
      .head_data    (head_data),
      .head_channel (head_channel),
      .head_sop     (head_sop),
      .head_eop     (head_eop),
      .head_error   (head_error),
      .head_empty   (head_empty),
      .head_idles   (head_idles),
      .fifo_empty   (fifo_empty),
      .full         (full)
   );

   // ------------------------------------------------------------------------
   // drive and response processes
   // ------------------------------------------------------------------------

   st_beat_driver u_driver (
      .clk          (clk),
      .reset        (reset),
      .src_ready    (src_ready),
      .head_data    (head_data),
      .head_channel (head_channel),
      .head_sop     (head_sop),
      .head_eop     (head_eop),
      .head_error   (head_error),
      .head_empty   (head_empty),
      .head_idles   (head_idles),
      .fifo_empty   (fifo_empty),
      .push         (push),
      .pop          (pop),
      .src_valid    (src_valid),
      .src_data     (src_data),
      .src_channel  (src_channel),
      .src_sop      (src_sop),
      .src_eop      (src_eop),
      .src_error    (src_error),
      .src_empty    (src_empty),
      .complete     (complete)
   );

   // monitor watches the same valid that leaves the block
   st_backpressure_monitor u_monitor (
      .clk          (clk),
      .reset        (reset),
      .src_valid    (src_valid),
      .src_ready    (src_ready),
      .resp_valid   (resp_valid),
      .resp_latency (resp_latency),
      .resp_count   (resp_count),
      .timeout      (timeout)
   );

endmodule

// ==== source/st_backpressure_monitor.sv ====
// back-pressure monitor; counts stall cycles per beat, emits responses, raises sticky timeout
`timescale 1ns/1ps

module st_backpressure_monitor
   import st_source_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     src_valid,
   input  logic     src_ready,
   output logic     resp_valid,
   output latency_t resp_latency,
   output count_t   resp_count,
   output logic     timeout
);

   // stall cycles of the beat on the bus
   latency_t stall_count;
   // accepted beats so far, index of the next response
   count_t   beat_count;
   logic     accept;
   logic     stall;

   assign accept = src_valid && src_ready;
   assign stall  = src_valid && !src_ready;

   // ------------------------------------------------------------------------
   // stall counter
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stall_count <= '0;
      end else if (accept) begin
         stall_count <= '0;
      end else if (stall && (stall_count != '1)) begin
         // saturate instead of wrapping
         stall_count <= stall_count + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // response strobe, one cycle after each accepting edge
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         resp_valid   <= 1'b0;
         resp_latency <= '0;
         resp_count   <= '0;
         beat_count   <= '0;
      end else begin
         resp_valid <= accept;
         if (accept) begin
            resp_latency <= stall_count;
            resp_count   <= beat_count;
            beat_count   <= beat_count + 1'b1;
         end
      end
   end

   // sticky until reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         timeout <= 1'b0;
      end else if (stall_count > latency_t'(response_timeout)) begin
         timeout <= 1'b1;
      end
   end

   // back-to-back responses belong to consecutive beats that met no back-pressure
   assert property (@(posedge clk) disable iff (reset)
      resp_valid && $past(resp_valid) |-> (resp_latency == '0)
         && (resp_count == $past(resp_count) + 1'b1))
      else $error("response strobe repeated without a second acceptance");

endmodule

// ==== source/st_beat_driver.sv ====
// beat driver FSM; pops queued beats, inserts idle gaps, drives valid/ready outputs, flags completion
`timescale 1ns/1ps

module st_beat_driver
   import st_source_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     src_ready,
   input  data_t    head_data,
   input  channel_t head_channel,
   input  logic     head_sop,
   input  logic     head_eop,
   input  error_t   head_error,
   input  empty_t   head_empty,
   input  idle_t    head_idles,
   input  logic     fifo_empty,
   input  logic     push,
   output logic     pop,
   output logic     src_valid,
   output data_t    src_data,
   output channel_t src_channel,
   output logic     src_sop,
   output logic     src_eop,
   output error_t   src_error,
   output empty_t   src_empty,
   output logic     complete
);

   driver_state_t state;
   // remaining idle cycles while in st_gap
   idle_t         gap_count;
   logic          accept;

   // loaded beat, held until accepted
   data_t    data_q;
   channel_t channel_q;
   logic     sop_q;
   logic     eop_q;
   error_t   error_q;
   empty_t   empty_q;

   // ------------------------------------------------------------------------
   // handshake and pop
   // ------------------------------------------------------------------------

   assign src_valid = (state == st_drive);
   assign accept    = src_valid && src_ready;
   // load from idle, or reload right at the accepting edge for back-to-back beats
   assign pop       = !fifo_empty && ((state == st_idle) || accept);

   // ------------------------------------------------------------------------
   // state machine
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= st_idle;
         gap_count <= '0;
      end else if (pop) begin
         // zero idles goes straight to drive, otherwise k cycles in st_gap
         state     <= (head_idles == '0) ? st_drive : st_gap;
         gap_count <= head_idles;
      end else begin
         case (state)
            st_gap: begin
               if (gap_count == idle_t'(1)) begin
                  state <= st_drive;
               end
               gap_count <= gap_count - 1'b1;
            end
            st_drive: begin
               // accepted with nothing queued
               if (src_ready) state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // payload registers, loaded on pop only
   always_ff @(posedge clk) begin
      if (pop) begin
         data_q    <= head_data;
         channel_q <= head_channel;
         sop_q     <= head_sop;
         eop_q     <= head_eop;
         error_q   <= head_error;
         empty_q   <= head_empty;
      end
   end

   // idle outputs are driven low
   assign src_data    = src_valid ? data_q    : '0;
   assign src_channel = src_valid ? channel_q : '0;
   assign src_sop     = src_valid && sop_q;
   assign src_eop     = src_valid && eop_q;
   assign src_error   = src_valid ? error_q   : '0;
   assign src_empty   = src_valid ? empty_q   : '0;

   // ------------------------------------------------------------------------
   // completion level
   // ------------------------------------------------------------------------

   // set when the last queued beat is taken, cleared by any new push
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         complete <= 1'b0;
      end else if (push) begin
         complete <= 1'b0;
      end else if (accept && fifo_empty) begin
         complete <= 1'b1;
      end
   end

   // a stalled beat keeps every stream output until the sink takes it
   assert property (@(posedge clk) disable iff (reset)
      src_valid && !src_ready |=> src_valid && $stable(src_data) && $stable(src_channel)
         && $stable(src_sop) && $stable(src_eop) && $stable(src_error) && $stable(src_empty))
      else $error("stream outputs changed under back-pressure");

endmodule

// ==== source/st_transaction_fifo.sv ====
// show-ahead transaction queue holding pushed beats and their idle counts for the beat driver
`timescale 1ns/1ps

module st_transaction_fifo
   import st_source_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     push,
   input  data_t    push_data,
   input  channel_t push_channel,
   input  logic     push_sop,
   input  logic     push_eop,
   input  error_t   push_error,
   input  empty_t   push_empty,
   input  idle_t    push_idles,
   input  logic     pop,
   output data_t    head_data,
   output channel_t head_channel,
   output logic     head_sop,
   output logic     head_eop,
   output error_t   head_error,
   output empty_t   head_empty,
   output idle_t    head_idles,
   output logic     fifo_empty,
   output logic     full
);

   // one array per field
   data_t    data_mem    [fifo_depth];
   channel_t channel_mem [fifo_depth];
   logic     sop_mem     [fifo_depth];
   logic     eop_mem     [fifo_depth];
   error_t   error_mem   [fifo_depth];
   empty_t   empty_mem   [fifo_depth];
   idle_t    idles_mem   [fifo_depth];

   // pointers wrap on their own since depth is a power of two
   logic [fifo_addr_w-1:0] wr_ptr;
   logic [fifo_addr_w-1:0] rd_ptr;
   logic [fifo_addr_w:0]   count;

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr]    <= push_data;
         channel_mem[wr_ptr] <= push_channel;
         sop_mem[wr_ptr]     <= push_sop;
         eop_mem[wr_ptr]     <= push_eop;
         error_mem[wr_ptr]   <= push_error;
         empty_mem[wr_ptr]   <= push_empty;
         idles_mem[wr_ptr]   <= push_idles;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         // occupancy only moves when exactly one side is active
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // oldest entry shown without latency
   assign head_data    = data_mem[rd_ptr];
   assign head_channel = channel_mem[rd_ptr];
   assign head_sop     = sop_mem[rd_ptr];
   assign head_eop     = eop_mem[rd_ptr];
   assign head_error   = error_mem[rd_ptr];
   assign head_empty   = empty_mem[rd_ptr];
   assign head_idles   = idles_mem[rd_ptr];

   assign fifo_empty = (count == '0);
   assign full       = (count == (fifo_addr_w + 1)'(fifo_depth));

   // host must watch full and driver must watch fifo_empty
   assert property (@(posedge clk) disable iff (reset) full |-> !push)
      else $error("push into full transaction queue");
   assert property (@(posedge clk) disable iff (reset) fifo_empty |-> !pop)
      else $error("pop from empty transaction queue");

endmodule

// ==== source/st_source_pkg.sv ====
// shared widths, depths, limits and types for the streaming packet source; import with ::*
package st_source_pkg;

   // ------------------------------------------------------------------------
   // beat geometry
   // ------------------------------------------------------------------------

   // bits per symbol and symbols per beat
   localparam int symbol_w    = 8;
   localparam int num_symbols = 4;
   // full beat width follows from the two above
   localparam int data_w      = symbol_w * num_symbols;
   localparam int channel_w   = 4;
   localparam int error_w     = 2;
   // unused symbols in the last beat of a packet
   localparam int empty_w     = 2;
   // idle cycles ahead of a beat, 15 at most
   localparam int idle_w      = 4;

   // ------------------------------------------------------------------------
   // queue, counters and limits
   // ------------------------------------------------------------------------

   localparam int fifo_depth  = 8;
   localparam int fifo_addr_w = 3;
   // back-pressure cycles seen by one beat, saturates
   localparam int latency_w   = 8;
   // index of the accepted beat in the response
   localparam int count_w     = 16;
   // longest legal wait for one beat, in cycles
   localparam int response_timeout = 16;

   // ------------------------------------------------------------------------
   // types
   // ------------------------------------------------------------------------

   typedef logic [data_w-1:0]    data_t;
   typedef logic [channel_w-1:0] channel_t;
   typedef logic [error_w-1:0]   error_t;
   typedef logic [empty_w-1:0]   empty_t;
   typedef logic [idle_w-1:0]    idle_t;
   typedef logic [latency_w-1:0] latency_t;
   typedef logic [count_w-1:0]   count_t;

   // beat driver FSM
   typedef enum logic [1:0] {
      // nothing loaded
      st_idle,
      // counting idle cycles, valid low
      st_gap,
      // valid asserted, waiting for ready
      st_drive
   } driver_state_t;

endpackage
